// ==== Bender.yml ====
package:
  name: alu_exec

sources:
  - hdl/alu_pkg.sv
  - hdl/alu_slave.sv
  - hdl/mul_div_unit.sv
  - hdl/alu_master.sv
  - target: simulation
    files:
      - tests/alu_sva.sv
      - tests/tb_alu.sv

// ==== all.f ====
hdl/alu_pkg.sv
hdl/alu_slave.sv
hdl/mul_div_unit.sv
hdl/alu_master.sv
tests/alu_sva.sv
tests/tb_alu.sv

// ==== hdl/alu_master.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu_master import alu_pkg::*; (
    input  wire           clk,
    input  wire           reset,
    input  wire           req_valid,
    output logic          req_ready,
    input  wire alu_req_t req,
    output logic          res_valid,
    input  wire           res_ready,
    output alu_res_t      res
);

    word_t    slave_y;
    logic     slave_overflow;

    logic     md_start;
    logic     md_busy;
    logic     md_done;
    md_kind_t md_kind;
    hilo_t    md_result;

    word_t    hi_q;
    word_t    lo_q;

    logic     accept;
    logic     is_md;
    alu_res_t next_res;

    alu_slave i_alu_slave (
        .op       (req.op),
        .a        (req.a),
        .b        (req.b),
        .y        (slave_y),
        .overflow (slave_overflow)
    );

    // Multiply/divide ops go to the iterative unit
    always_comb begin
        is_md   = 1'b1;
        md_kind = md_mult;
        case (req.op)
            op_mult:  md_kind = md_mult;
            op_multu: md_kind = md_multu;
            op_div:   md_kind = md_div;
            op_divu:  md_kind = md_divu;
            default:  is_md   = 1'b0;
        endcase
    end

    // Idle and the output register free, or emptied this cycle
    assign req_ready = !md_busy && (!res_valid || res_ready);
    assign accept    = req_valid && req_ready;
    assign md_start  = accept && is_md;

    mul_div_unit i_mul_div_unit (
        .clk    (clk),
        .reset  (reset),
        .start  (md_start),
        .kind   (md_kind),
        .a      (req.a),
        .b      (req.b),
        .busy   (md_busy),
        .done   (md_done),
        .result (md_result)
    );

    // Single-cycle result, HI/LO moves override the ALU output
    always_comb begin
        next_res.y        = slave_y;
        next_res.overflow = slave_overflow;
        case (req.op)
            op_mfhi: begin
                next_res = '{y: hi_q, overflow: 1'b0};
            end
            op_mflo: begin
                next_res = '{y: lo_q, overflow: 1'b0};
            end
            op_mthi,
            op_mtlo: begin
                next_res = '{y: req.a, overflow: 1'b0};
            end
            default: begin
                next_res.y        = slave_y;
                next_res.overflow = slave_overflow;
            end
        endcase
    end

    // No request is accepted while the unit is busy, so done never meets a move
    always_ff @(posedge clk) begin
        if (reset) begin
            hi_q <= '0;
            lo_q <= '0;
        end else if (md_done) begin
            hi_q <= md_result.hi;
            lo_q <= md_result.lo;
        end else if (accept && req.op == op_mthi) begin
            hi_q <= req.a;
        end else if (accept && req.op == op_mtlo) begin
            lo_q <= req.a;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            res_valid <= 1'b0;
        end else if ((accept && !is_md) || md_done) begin
            res_valid <= 1'b1;
        end else if (res_ready) begin
            res_valid <= 1'b0;
        end
    end

    // Multiply/divide responds with the new LO
    always_ff @(posedge clk) begin
        if (md_done) begin
            res <= '{y: md_result.lo, overflow: 1'b0};
        end else if (accept && !is_md) begin
            res <= next_res;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/alu_pkg.sv ====
`default_nettype none

package alu_pkg;

    // Multiply/divide iteration count and request-to-result latency
    localparam int md_steps   = 32;
    localparam int md_latency = md_steps + 2;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  shamt_t;

    // Step counter of the multiply/divide engine
    typedef logic [$clog2(md_steps)-1:0] md_count_t;

    // Grouped by function, one group per 8 codes
    typedef enum logic [7:0] {
        op_add   = 8'h00,
        op_addu  = 8'h01,
        op_sub   = 8'h02,
        op_subu  = 8'h03,

        op_slt   = 8'h08,
        op_sltu  = 8'h09,
        op_slti  = 8'h0a,
        op_sltiu = 8'h0b,

        op_and   = 8'h10,
        op_or    = 8'h11,
        op_nor   = 8'h12,
        op_xor   = 8'h13,
        op_lui   = 8'h14,

        op_sll   = 8'h18,
        op_sllv  = 8'h19,
        op_srl   = 8'h1a,
        op_srlv  = 8'h1b,
        op_sra   = 8'h1c,
        op_srav  = 8'h1d,

        op_mult  = 8'h20,
        op_multu = 8'h21,
        op_div   = 8'h22,
        op_divu  = 8'h23,

        op_mfhi  = 8'h28,
        op_mflo  = 8'h29,
        op_mthi  = 8'h2a,
        op_mtlo  = 8'h2b
    } alu_op_t;

    typedef struct packed {
        alu_op_t op;
        word_t   a;
        word_t   b;
    } alu_req_t;

    typedef struct packed {
        word_t y;
        logic  overflow;
    } alu_res_t;

    typedef enum logic [1:0] {
        md_mult,
        md_multu,
        md_div,
        md_divu
    } md_kind_t;

    // hi in the upper half, so {hi, lo} reads as the 64-bit product
    typedef struct packed {
        word_t hi;
        word_t lo;
    } hilo_t;

endpackage

`default_nettype wire

// ==== hdl/alu_slave.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu_slave import alu_pkg::*; (
    input  wire alu_op_t op,
    input  wire word_t   a,
    input  wire word_t   b,
    output word_t        y,
    output logic         overflow
);

    word_t  sum;
    word_t  diff;
    shamt_t shamt;

    assign sum   = a + b;
    assign diff  = a - b;

    // Both shift forms take the amount from a
    assign shamt = a[4:0];

    always_comb begin
        y        = '0;
        overflow = 1'b0;
        case (op)
            op_add: begin
                y        = sum;
                // Same-sign operands whose sum flips sign
                overflow = (a[31] == b[31]) && (sum[31] != a[31]);
            end
            op_addu: begin
                y = sum;
            end
            op_sub: begin
                y        = diff;
                overflow = (a[31] != b[31]) && (diff[31] != a[31]);
            end
            op_subu: begin
                y = diff;
            end

            op_slt,
            op_slti: begin
                y = {31'b0, $signed(a) < $signed(b)};
            end
            op_sltu,
            op_sltiu: begin
                y = {31'b0, a < b};
            end

            op_and: y = a & b;
            op_or:  y = a | b;
            op_nor: y = ~(a | b);
            op_xor: y = a ^ b;
            op_lui: y = {b[15:0], 16'b0};

            op_sll,
            op_sllv: begin
                y = b << shamt;
            end
            op_srl,
            op_srlv: begin
                y = b >> shamt;
            end
            op_sra,
            op_srav: begin
                y = $signed(b) >>> shamt;
            end

            default: begin
                y        = '0;
                overflow = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/mul_div_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module mul_div_unit import alu_pkg::*; (
    input  wire           clk,
    input  wire           reset,
    input  wire           start,
    input  wire md_kind_t kind,
    input  wire word_t    a,
    input  wire word_t    b,
    output logic          busy,
    output logic          done,
    output hilo_t         result
);

    typedef enum logic [1:0] {
        st_idle,
        st_run,
        st_finish
    } md_state_t;

    md_state_t   state;
    md_count_t   count;

    // hi_q is the partial product or the remainder, lo_q the multiplier or the quotient
    word_t       hi_q;
    word_t       lo_q;
    word_t       m_q;
    logic        is_div;
    logic        neg_lo;
    logic        neg_rem;

    logic        signed_op;
    word_t       mag_a;
    word_t       mag_b;
    logic [32:0] mul_sum;
    logic [32:0] div_shift;
    logic [33:0] div_diff;
    logic [63:0] prod_neg;

    // Signed kinds run on magnitudes
    always_comb begin
        signed_op = (kind == md_mult) || (kind == md_div);
        mag_a     = (signed_op && a[31]) ? -a : a;
        mag_b     = (signed_op && b[31]) ? -b : b;
    end

    // Multiply step adds the multiplicand when the low multiplier bit is set
    assign mul_sum   = {1'b0, hi_q} + (lo_q[0] ? {1'b0, m_q} : 33'd0);

    // Divide step shifts in the next dividend bit and tries a subtract
    assign div_shift = {hi_q, lo_q[31]};
    assign div_diff  = {1'b0, div_shift} - {2'b0, m_q};

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        state <= st_run;
                    end
                end
                st_run: begin
                    if (count == md_count_t'(md_steps - 1)) begin
                        state <= st_finish;
                    end
                end
                st_finish: begin
                    state <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && start) begin
            // Same load for both: a goes in lo, b is the multiplicand or divisor
            hi_q    <= '0;
            lo_q    <= mag_a;
            m_q     <= mag_b;
            count   <= '0;
            is_div  <= (kind == md_div) || (kind == md_divu);
            neg_lo  <= signed_op && (a[31] ^ b[31]);
            neg_rem <= (kind == md_div) && a[31];
        end else if (state == st_run) begin
            count <= count + 1'b1;
            if (is_div) begin
                if (!div_diff[33]) begin
                    hi_q <= div_diff[31:0];
                    lo_q <= {lo_q[30:0], 1'b1};
                end else begin
                    hi_q <= div_shift[31:0];
                    lo_q <= {lo_q[30:0], 1'b0};
                end
            end else begin
                hi_q <= mul_sum[32:1];
                lo_q <= {mul_sum[0], lo_q[31:1]};
            end
        end
    end

    assign prod_neg = -{hi_q, lo_q};

    // Sign fix on the way out
    always_comb begin
        if (is_div) begin
            result.lo = neg_lo ? -lo_q : lo_q;
            result.hi = neg_rem ? -hi_q : hi_q;
        end else if (neg_lo) begin
            result = prod_neg;
        end else begin
            result = {hi_q, lo_q};
        end
    end

    assign busy = (state != st_idle);
    assign done = (state == st_finish);

endmodule

`default_nettype wire

// ==== tests/alu_sva.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu_sva import alu_pkg::*; (
    input wire           clk,
    input wire           reset,
    input wire           req_valid,
    input wire           req_ready,
    input wire alu_req_t req,
    input wire           res_valid,
    input wire           res_ready,
    input wire alu_res_t res,
    input wire           start,
    input wire           busy
);

    // A stalled request stays valid and unchanged
    req_stable_a: assert property (
        @(posedge clk) disable iff (reset)
        req_valid && !req_ready |=> req_valid && $stable(req)
    ) else $error("request changed while stalled");

    res_stable_a: assert property (
        @(posedge clk) disable iff (reset)
        res_valid && !res_ready |=> res_valid && $stable(res)
    ) else $error("result changed under back-pressure");

    backpressure_a: assert property (
        @(posedge clk) disable iff (reset)
        res_valid && !res_ready |-> !req_ready
    ) else $error("request accepted while the result is stalled");

    // Multiply/divide answers a fixed number of cycles after acceptance
    md_latency_a: assert property (
        @(posedge clk) disable iff (reset)
        start |-> ##md_latency res_valid
    ) else $error("multiply/divide result not valid after its fixed latency");

    // Every other accepted request answers in the next cycle
    alu_latency_a: assert property (
        @(posedge clk) disable iff (reset)
        req_valid && req_ready && !start |=> res_valid
    ) else $error("single-cycle result not valid in the cycle after acceptance");

    reset_state_a: assert property (
        @(posedge clk)
        reset |=> !res_valid && !busy && req_ready
    ) else $error("stage not idle after reset");

endmodule

bind alu_master alu_sva i_alu_sva (
    .clk       (clk),
    .reset     (reset),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req       (req),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .res       (res),
    .start     (md_start),
    .busy      (md_busy)
);

`default_nettype wire

// ==== tests/tb_alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_alu import alu_pkg::*; ();

    localparam int num_requests  = 500;
    localparam int timeout_limit = num_requests * (md_latency + 10) + 100;
    localparam int clk_half      = 10;

    typedef struct packed {
        alu_op_t  op;
        alu_res_t res;
        hilo_t    hilo;
    } expect_t;

    logic     clk;
    logic     reset;
    logic     req_valid;
    logic     req_ready;
    alu_req_t req;
    logic     res_valid;
    logic     res_ready;
    alu_res_t res;

    expect_t  expected_q[$];
    hilo_t    model_hilo;
    integer   seed;
    int       sent;
    int       received;
    int       cycles;
    logic     taken;

    alu_op_t  op_list [0:26] = '{
        op_add, op_addu, op_sub, op_subu,
        op_slt, op_sltu, op_slti, op_sltiu,
        op_and, op_or, op_nor, op_xor, op_lui,
        op_sll, op_sllv, op_srl, op_srlv, op_sra, op_srav,
        op_mult, op_multu, op_div, op_divu,
        op_mfhi, op_mflo, op_mthi, op_mtlo
    };

    alu_master i_alu_master (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res       (res)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(clk_half) clk = ~clk;
        end
    end

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "%s", msg);
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            stop_with_failure($sformatf("CHECK FAILED %s: expected 0x%08h, got 0x%08h",
                                        name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_with_failure($sformatf("CHECK FAILED %s: expected 0x%h, got 0x%h",
                                        name, exp, act));
        end
    endtask

    task automatic check_hilo(input string name, input hilo_t exp, input hilo_t act);
        if (act !== exp) begin
            stop_with_failure($sformatf("CHECK FAILED %s: expected 0x%016h, got 0x%016h",
                                        name, exp, act));
        end
    endtask

    // Edge values show up often to hit overflow, sign and divide-by-zero cases
    function automatic word_t rand_operand();
        case ($unsigned($random(seed)) % 8)
            0: return 32'h0000_0000;
            1: return 32'h7fff_ffff;
            2: return 32'h8000_0000;
            3: return 32'hffff_ffff;
            4: return word_t'($unsigned($random(seed)) % 32);
            default: return word_t'($random(seed));
        endcase
    endfunction

    function automatic alu_res_t model_alu(input alu_op_t op, input word_t a, input word_t b);
        longint   wide;
        alu_res_t r;
        shamt_t   sh;
        r  = '0;
        sh = a[4:0];
        case (op)
            op_add, op_addu: begin
                wide       = longint'($signed(a)) + longint'($signed(b));
                r.y        = word_t'(wide);
                // Overflow when the true sum does not fit in 32 signed bits
                r.overflow = (op == op_add) && (wide != longint'($signed(r.y)));
            end
            op_sub, op_subu: begin
                wide       = longint'($signed(a)) - longint'($signed(b));
                r.y        = word_t'(wide);
                r.overflow = (op == op_sub) && (wide != longint'($signed(r.y)));
            end
            op_slt, op_slti:   r.y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            op_sltu, op_sltiu: r.y = (a < b) ? 32'd1 : 32'd0;
            op_and:            r.y = a & b;
            op_or:             r.y = a | b;
            op_nor:            r.y = ~(a | b);
            op_xor:            r.y = a ^ b;
            op_lui:            r.y = {b[15:0], 16'h0000};
            op_sll, op_sllv:   r.y = b << sh;
            op_srl, op_srlv:   r.y = b >> sh;
            op_sra, op_srav:   r.y = word_t'($signed(b) >>> sh);
            default:           r = '0;
        endcase
        return r;
    endfunction

    function automatic hilo_t model_muldiv(input alu_op_t op, input word_t a, input word_t b);
        longint sa;
        longint sb;
        hilo_t  r;
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        r  = '0;
        case (op)
            op_mult:  r = hilo_t'(sa * sb);
            op_multu: r = hilo_t'({32'h0, a} * {32'h0, b});
            op_div: begin
                if (b == '0) begin
                    // All-ones quotient magnitude, negated for a negative dividend
                    r.lo = a[31] ? 32'h0000_0001 : 32'hffff_ffff;
                    r.hi = a;
                end else begin
                    r.lo = word_t'(sa / sb);
                    r.hi = word_t'(sa % sb);
                end
            end
            op_divu: begin
                r.lo = (b == '0) ? 32'hffff_ffff : a / b;
                r.hi = (b == '0) ? a : a % b;
            end
            default: r = '0;
        endcase
        return r;
    endfunction

    task automatic model_accept(input alu_req_t r);
        expect_t e;
        e.op  = r.op;
        e.res = model_alu(r.op, r.a, r.b);
        case (r.op)
            op_mult, op_multu, op_div, op_divu: begin
                model_hilo = model_muldiv(r.op, r.a, r.b);
                e.res      = '{y: model_hilo.lo, overflow: 1'b0};
            end
            op_mfhi: e.res = '{y: model_hilo.hi, overflow: 1'b0};
            op_mflo: e.res = '{y: model_hilo.lo, overflow: 1'b0};
            op_mthi: begin
                model_hilo.hi = r.a;
                e.res         = '{y: r.a, overflow: 1'b0};
            end
            op_mtlo: begin
                model_hilo.lo = r.a;
                e.res         = '{y: r.a, overflow: 1'b0};
            end
            default: ;
        endcase
        e.hilo = model_hilo;
        expected_q.push_back(e);
    endtask

    task automatic check_result(input alu_res_t got);
        expect_t e;
        hilo_t   seen;
        if (expected_q.size() == 0) begin
            stop_with_failure("A result came out with no request outstanding");
        end
        e = expected_q.pop_front();
        // HI/LO reads stand in for the register pair
        if (e.op == op_mfhi || e.op == op_mflo) begin
            seen = e.hilo;
            if (e.op == op_mfhi) begin
                seen.hi = got.y;
            end else begin
                seen.lo = got.y;
            end
            check_hilo($sformatf("hilo via %s", e.op.name()), e.hilo, seen);
        end
        check_word($sformatf("res.y for %s", e.op.name()), e.res.y, got.y);
        check_flag($sformatf("res.overflow for %s", e.op.name()), e.res.overflow, got.overflow);
    endtask

    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > timeout_limit) begin
                stop_with_failure($sformatf("Timeout after %0d cycles with %0d of %0d results seen",
                                            cycles, received, num_requests));
            end
        end
    end

    initial begin
        seed       = 57169;
        reset      = 1'b1;
        req_valid  = 1'b0;
        req        = '0;
        res_ready  = 1'b0;
        model_hilo = '0;
        sent       = 0;
        received   = 0;
        taken      = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        while (received < num_requests) begin
            @(negedge clk);
            if (taken) begin
                req_valid = 1'b0;
                taken     = 1'b0;
            end
            if (!req_valid && sent < num_requests && ($random(seed) & 3) != 0) begin
                req.op    = op_list[$unsigned($random(seed)) % $size(op_list)];
                req.a     = rand_operand();
                req.b     = rand_operand();
                req_valid = 1'b1;
            end
            res_ready = ($random(seed) & 3) != 0;
            // Handshakes are decided on values that hold until the next rising edge
            #1;
            if (res_valid && res_ready) begin
                check_result(res);
                received++;
            end
            if (req_valid && req_ready) begin
                model_accept(req);
                sent++;
                taken = 1'b1;
            end
        end

        req_valid = 1'b0;
        res_ready = 1'b1;
        repeat (md_latency + 5) begin
            @(negedge clk);
            if (res_valid) begin
                stop_with_failure("An extra result came out after all requests were answered");
            end
        end
        if (received != sent || expected_q.size() != 0) begin
            stop_with_failure($sformatf("Accepted %0d requests but saw %0d results",
                                        sent, received));
        end else begin
            $display("SIMULATION PASSED");
        end
        $finish;
    end

endmodule

`default_nettype wire
